/* vmul_config.svh */
`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// operand and result word
`define VMUL_DATA_W 64

// destination tag carried with each request
`define VMUL_ADDR_W 32

// 32-bit multiply lanes in the execute stage
`define VMUL_LANES 4

// 16-bit half plus one extension bit
`define VMUL_SUB_W 17

// request to response, in clock edges
`define VMUL_LATENCY 6

`endif

/* vmul_pkg.sv */
`default_nettype none

package vmul_pkg;

`include "vmul_config.svh"

	typedef enum logic [1:0] {
		SEW8  = 2'd0,
		SEW16 = 2'd1,
		SEW32 = 2'd2,
		SEW64 = 2'd3
	} sew_t;

	// mulhsu takes in_vec0 as signed and in_vec1 as unsigned
	typedef enum logic [1:0] {
		OP_MULHU  = 2'b00,
		OP_MUL    = 2'b01,
		OP_MULHSU = 2'b10,
		OP_MULH   = 2'b11
	} mul_op_t;

	// element 0 is the least significant in every view
	typedef union packed {
		logic [`VMUL_DATA_W/8-1:0][7:0]   bytes;
		logic [`VMUL_DATA_W/16-1:0][15:0] halves;
		logic [`VMUL_DATA_W/32-1:0][31:0] words;
	} vec_word_t;

	typedef logic signed [`VMUL_SUB_W-1:0] sub_operand_t;

	typedef struct packed {
		sub_operand_t a1;
		sub_operand_t a0;
		sub_operand_t b1;
		sub_operand_t b0;
	} lane_operands_t;

	// full is the 33 x 33 product of {a1, a0[15:0]} and {b1, b0[15:0]}
	typedef struct packed {
		logic signed [4*`VMUL_SUB_W-3:0] full;
		logic signed [2*`VMUL_SUB_W-1:0] p1;
		logic signed [2*`VMUL_SUB_W-1:0] p0;
	} lane_products_t;

endpackage

`default_nettype wire

/* vmul_lane.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_lane import vmul_pkg::*; (
	input  logic           clk,
	input  logic           rst,
	input  lane_operands_t lane_in,
	output lane_products_t lane_out
);

	localparam int HALF_W = `VMUL_SUB_W - 1;
	localparam int PP_W   = 2 * `VMUL_SUB_W;
	localparam int FULL_W = 4 * `VMUL_SUB_W - 2;

	logic signed [PP_W-1:0]   s1_ll;
	logic signed [PP_W-1:0]   s1_lh;
	logic signed [PP_W-1:0]   s1_hl;
	logic signed [PP_W-1:0]   s1_hh;
	logic signed [PP_W-1:0]   s2_ll;
	logic signed [PP_W-1:0]   s2_hh;
	logic signed [PP_W:0]     s2_cross;
	logic signed [PP_W-1:0]   s3_p0;
	logic signed [PP_W-1:0]   s3_p1;
	logic signed [FULL_W-1:0] s3_full;
	logic [FULL_W-1:0]        hh_term;
	logic [FULL_W-1:0]        cross_term;
	logic [FULL_W-1:0]        ll_term;

	// align the three partial sums on the 66-bit result
	assign hh_term    = {s2_hh, {(2*HALF_W){1'b0}}};
	assign cross_term = {{(FULL_W-PP_W-1-HALF_W){s2_cross[PP_W]}}, s2_cross, {HALF_W{1'b0}}};
	assign ll_term    = {{(FULL_W-PP_W){s2_ll[PP_W-1]}}, s2_ll};

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_ll    <= '0;
			s1_lh    <= '0;
			s1_hl    <= '0;
			s1_hh    <= '0;
			s2_ll    <= '0;
			s2_hh    <= '0;
			s2_cross <= '0;
			s3_p0    <= '0;
			s3_p1    <= '0;
			s3_full  <= '0;
			lane_out <= '0;
		end else begin
			s1_ll    <= $signed(lane_in.a0) * $signed(lane_in.b0);
			s1_lh    <= $signed(lane_in.a0) * $signed(lane_in.b1);
			s1_hl    <= $signed(lane_in.a1) * $signed(lane_in.b0);
			s1_hh    <= $signed(lane_in.a1) * $signed(lane_in.b1);

			s2_ll    <= s1_ll;
			s2_hh    <= s1_hh;
			s2_cross <= s1_lh + s1_hl;

			s3_p0    <= s2_ll;
			s3_p1    <= s2_hh;
			s3_full  <= $signed(hh_term + cross_term + ll_term);

			lane_out.p0   <= s3_p0;
			lane_out.p1   <= s3_p1;
			lane_out.full <= s3_full;
		end
	end

endmodule

`default_nettype wire

/* vmul_decode.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_decode import vmul_pkg::*; (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  in_valid,
	input  vec_word_t                             in_vec0,
	input  vec_word_t                             in_vec1,
	input  sew_t                                  in_sew,
	input  mul_op_t                               in_op,
	input  logic [`VMUL_ADDR_W-1:0]               in_addr,
	output logic                                  d_valid,
	output sew_t                                  d_sew,
	output logic                                  d_hi,
	output logic [`VMUL_ADDR_W-1:0]               d_addr,
	output lane_operands_t [`VMUL_LANES-1:0]      d_lanes
);

	localparam int LAST = `VMUL_LANES - 1;

	logic a_signed;
	logic b_signed;
	lane_operands_t [`VMUL_LANES-1:0] lanes_next;

	function automatic sub_operand_t ext8(input logic [7:0] v, input logic sgn);
		return {{(`VMUL_SUB_W - 8){sgn & v[7]}}, v};
	endfunction

	function automatic sub_operand_t ext16(input logic [15:0] v, input logic sgn);
		return {sgn & v[15], v};
	endfunction

	// low product does not depend on signedness, so OP_MUL takes the signed path
	assign a_signed = (in_op != OP_MULHU);
	assign b_signed = in_op[0];

	always_comb begin
		lanes_next = '0;
		case (in_sew)
			SEW8: begin
				// lane k takes bytes 2k and 2k+1 in its two half slots
				for (int k = 0; k < `VMUL_LANES; k++) begin
					lanes_next[k].a0 = ext8(in_vec0.bytes[2*k], a_signed);
					lanes_next[k].a1 = ext8(in_vec0.bytes[2*k+1], a_signed);
					lanes_next[k].b0 = ext8(in_vec1.bytes[2*k], b_signed);
					lanes_next[k].b1 = ext8(in_vec1.bytes[2*k+1], b_signed);
				end
			end
			SEW16: begin
				lanes_next[0].a0    = ext16(in_vec0.halves[0], a_signed);
				lanes_next[0].a1    = ext16(in_vec0.halves[1], a_signed);
				lanes_next[0].b0    = ext16(in_vec1.halves[0], b_signed);
				lanes_next[0].b1    = ext16(in_vec1.halves[1], b_signed);
				lanes_next[LAST].a0 = ext16(in_vec0.halves[2], a_signed);
				lanes_next[LAST].a1 = ext16(in_vec0.halves[3], a_signed);
				lanes_next[LAST].b0 = ext16(in_vec1.halves[2], b_signed);
				lanes_next[LAST].b1 = ext16(in_vec1.halves[3], b_signed);
			end
			SEW32: begin
				// low halves are plain magnitudes, the sign sits in the high half
				lanes_next[0].a0    = ext16(in_vec0.words[0][15:0], 1'b0);
				lanes_next[0].a1    = ext16(in_vec0.words[0][31:16], a_signed);
				lanes_next[0].b0    = ext16(in_vec1.words[0][15:0], 1'b0);
				lanes_next[0].b1    = ext16(in_vec1.words[0][31:16], b_signed);
				lanes_next[LAST].a0 = ext16(in_vec0.words[1][15:0], 1'b0);
				lanes_next[LAST].a1 = ext16(in_vec0.words[1][31:16], a_signed);
				lanes_next[LAST].b0 = ext16(in_vec1.words[1][15:0], 1'b0);
				lanes_next[LAST].b1 = ext16(in_vec1.words[1][31:16], b_signed);
			end
			default: begin
				// 64-bit elements are not supported, lanes stay at zero
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			d_valid <= 1'b0;
			d_sew   <= SEW8;
			d_hi    <= 1'b0;
			d_addr  <= '0;
			d_lanes <= '0;
		end else begin
			d_valid <= in_valid;
			d_sew   <= in_valid ? in_sew : SEW8;
			d_hi    <= in_valid & (in_op != OP_MUL);
			d_addr  <= in_valid ? in_addr : '0;
			d_lanes <= lanes_next;
		end
	end

endmodule

`default_nettype wire

/* vmul_execute.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_execute import vmul_pkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             d_valid,
	input  sew_t                             d_sew,
	input  logic                             d_hi,
	input  logic [`VMUL_ADDR_W-1:0]          d_addr,
	input  lane_operands_t [`VMUL_LANES-1:0] d_lanes,
	output logic                             x_valid,
	output sew_t                             x_sew,
	output logic                             x_hi,
	output logic [`VMUL_ADDR_W-1:0]          x_addr,
	output lane_products_t [`VMUL_LANES-1:0] x_products
);

	// decode and result take one cycle each, the lanes take the rest
	localparam int DEPTH = `VMUL_LATENCY - 2;

	logic [DEPTH-1:0]       valid_pipe;
	logic [DEPTH-1:0]       hi_pipe;
	sew_t                   sew_pipe [DEPTH];
	logic [`VMUL_ADDR_W-1:0] addr_pipe [DEPTH];

	genvar g;
	generate
		for (g = 0; g < `VMUL_LANES; g++) begin : g_lane
			vmul_lane i_lane (
				.clk      (clk),
				.rst      (rst),
				.lane_in  (d_lanes[g]),
				.lane_out (x_products[g])
			);
		end
	endgenerate

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_pipe <= '0;
			hi_pipe    <= '0;
			for (int i = 0; i < DEPTH; i++) begin
				sew_pipe[i]  <= SEW8;
				addr_pipe[i] <= '0;
			end
		end else begin
			valid_pipe <= {valid_pipe[DEPTH-2:0], d_valid};
			hi_pipe    <= {hi_pipe[DEPTH-2:0], d_hi};
			sew_pipe[0]  <= d_sew;
			addr_pipe[0] <= d_addr;
			for (int i = 1; i < DEPTH; i++) begin
				sew_pipe[i]  <= sew_pipe[i-1];
				addr_pipe[i] <= addr_pipe[i-1];
			end
		end
	end

	assign x_valid = valid_pipe[DEPTH-1];
	assign x_hi    = hi_pipe[DEPTH-1];
	assign x_sew   = sew_pipe[DEPTH-1];
	assign x_addr  = addr_pipe[DEPTH-1];

endmodule

`default_nettype wire

/* vmul_result.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_result import vmul_pkg::*; (
	input  logic                             clk,
	input  logic                             rst,
	input  logic                             x_valid,
	input  sew_t                             x_sew,
	input  logic                             x_hi,
	input  logic [`VMUL_ADDR_W-1:0]          x_addr,
	input  lane_products_t [`VMUL_LANES-1:0] x_products,
	output logic                             out_valid,
	output vec_word_t                        out_vec,
	output logic [`VMUL_ADDR_W-1:0]          out_addr
);

	localparam int LAST   = `VMUL_LANES - 1;
	localparam int PP_W   = 2 * `VMUL_SUB_W;
	localparam int FULL_W = 4 * `VMUL_SUB_W - 2;

	vec_word_t vec_next;

	function automatic logic [7:0] pick8(input logic [PP_W-1:0] p, input logic hi);
		return hi ? p[15:8] : p[7:0];
	endfunction

	function automatic logic [15:0] pick16(input logic [PP_W-1:0] p, input logic hi);
		return hi ? p[31:16] : p[15:0];
	endfunction

	function automatic logic [31:0] pick32(input logic [FULL_W-1:0] p, input logic hi);
		return hi ? p[63:32] : p[31:0];
	endfunction

	// element to lane mapping mirrors the decode stage
	always_comb begin
		vec_next = '0;
		case (x_sew)
			SEW8: begin
				for (int k = 0; k < `VMUL_LANES; k++) begin
					vec_next.bytes[2*k]   = pick8(x_products[k].p0, x_hi);
					vec_next.bytes[2*k+1] = pick8(x_products[k].p1, x_hi);
				end
			end
			SEW16: begin
				vec_next.halves[0] = pick16(x_products[0].p0, x_hi);
				vec_next.halves[1] = pick16(x_products[0].p1, x_hi);
				vec_next.halves[2] = pick16(x_products[LAST].p0, x_hi);
				vec_next.halves[3] = pick16(x_products[LAST].p1, x_hi);
			end
			SEW32: begin
				vec_next.words[0] = pick32(x_products[0].full, x_hi);
				vec_next.words[1] = pick32(x_products[LAST].full, x_hi);
			end
			default: begin
				// SEW64 returns an all-zero word
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
			out_addr  <= '0;
			out_vec   <= '0;
		end else begin
			out_valid <= x_valid;
			out_addr  <= x_valid ? x_addr : '0;
			out_vec   <= vec_next;
		end
	end

endmodule

`default_nettype wire

/* vmul_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_top import vmul_pkg::*; (
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    in_valid,
	input  vec_word_t               in_vec0,
	input  vec_word_t               in_vec1,
	input  sew_t                    in_sew,
	input  mul_op_t                 in_op,
	input  logic [`VMUL_ADDR_W-1:0] in_addr,
	output logic                    out_valid,
	output vec_word_t               out_vec,
	output logic [`VMUL_ADDR_W-1:0] out_addr
);

	logic                             d_valid;
	sew_t                             d_sew;
	logic                             d_hi;
	logic [`VMUL_ADDR_W-1:0]          d_addr;
	lane_operands_t [`VMUL_LANES-1:0] d_lanes;

	logic                             x_valid;
	sew_t                             x_sew;
	logic                             x_hi;
	logic [`VMUL_ADDR_W-1:0]          x_addr;
	lane_products_t [`VMUL_LANES-1:0] x_products;

	// one cycle
	vmul_decode i_decode (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_vec0  (in_vec0),
		.in_vec1  (in_vec1),
		.in_sew   (in_sew),
		.in_op    (in_op),
		.in_addr  (in_addr),
		.d_valid  (d_valid),
		.d_sew    (d_sew),
		.d_hi     (d_hi),
		.d_addr   (d_addr),
		.d_lanes  (d_lanes)
	);

	// four cycles
	vmul_execute i_execute (
		.clk        (clk),
		.rst        (rst),
		.d_valid    (d_valid),
		.d_sew      (d_sew),
		.d_hi       (d_hi),
		.d_addr     (d_addr),
		.d_lanes    (d_lanes),
		.x_valid    (x_valid),
		.x_sew      (x_sew),
		.x_hi       (x_hi),
		.x_addr     (x_addr),
		.x_products (x_products)
	);

	// one cycle
	vmul_result i_result (
		.clk        (clk),
		.rst        (rst),
		.x_valid    (x_valid),
		.x_sew      (x_sew),
		.x_hi       (x_hi),
		.x_addr     (x_addr),
		.x_products (x_products),
		.out_valid  (out_valid),
		.out_vec    (out_vec),
		.out_addr   (out_addr)
	);

endmodule

`default_nettype wire

/* vmul_asserts.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module vmul_asserts import vmul_pkg::*; (
	input logic                    clk,
	input logic                    rst,
	input logic                    in_valid,
	input logic                    out_valid,
	input vec_word_t               out_vec,
	input logic [`VMUL_ADDR_W-1:0] out_addr
);

	int fail_count = 0;

	// fixed latency, no stalls anywhere in the pipe
	a_latency: assert property (@(posedge clk) disable iff (rst)
		out_valid == $past(in_valid, `VMUL_LATENCY))
		else begin
			$error("out_valid does not follow in_valid by the pipeline latency");
			fail_count++;
		end

	a_addr_idle: assert property (@(posedge clk) disable iff (rst)
		!out_valid |-> out_addr == '0)
		else begin
			$error("out_addr is not zero while out_valid is low");
			fail_count++;
		end

	a_vec_known: assert property (@(posedge clk) disable iff (rst)
		out_valid |-> !$isunknown(out_vec))
		else begin
			$error("out_vec has unknown bits while out_valid is high");
			fail_count++;
		end

endmodule

bind vmul_top vmul_asserts i_asserts (
	.clk       (clk),
	.rst       (rst),
	.in_valid  (in_valid),
	.out_valid (out_valid),
	.out_vec   (out_vec),
	.out_addr  (out_addr)
);

`default_nettype wire

/* tb_vmul.sv */
`timescale 1ns/10ps
`default_nettype none

`include "vmul_config.svh"

module tb_vmul import vmul_pkg::*; ();

	localparam int ADDR_W       = `VMUL_ADDR_W;
	localparam int LATENCY      = `VMUL_LATENCY;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_TESTS    = 5;
	localparam int SLOTS_IDLE   = 12;
	localparam int SLOTS_DIR    = 60;
	localparam int SLOTS_MIX    = 200;
	localparam int TOTAL_SLOTS  = SLOTS_IDLE + 3 * SLOTS_DIR + SLOTS_MIX;
	// every test drains its requests before the next one starts
	localparam int CYCLE_LIMIT  = RESET_CYCLES + TOTAL_SLOTS + NUM_TESTS * (LATENCY + 2) + 20;

	logic              clk;
	logic              rst;
	logic              in_valid;
	vec_word_t         in_vec0;
	vec_word_t         in_vec1;
	sew_t              in_sew;
	mul_op_t           in_op;
	logic [ADDR_W-1:0] in_addr;
	logic              out_valid;
	vec_word_t         out_vec;
	logic [ADDR_W-1:0] out_addr;

	integer            seed = 32'h783a;
	int                errors = 0;
	int                requests = 0;
	int                responses = 0;
	int                cycle_count = 0;
	vec_word_t         exp_vec_q[$];
	logic [ADDR_W-1:0] exp_addr_q[$];

	vmul_top i_dut (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_vec0   (in_vec0),
		.in_vec1   (in_vec1),
		.in_sew    (in_sew),
		.in_op     (in_op),
		.in_addr   (in_addr),
		.out_valid (out_valid),
		.out_vec   (out_vec),
		.out_addr  (out_addr)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// element-wise product with each operand extended by its own signedness
	function automatic vec_word_t model_mul(input vec_word_t a, input vec_word_t b,
		input sew_t sew, input mul_op_t op);
		int         w;
		int         n;
		logic       a_s;
		logic       b_s;
		logic [127:0] mask;
		logic [127:0] ea;
		logic [127:0] eb;
		logic [127:0] prod;
		logic [127:0] elem;
		logic [63:0]  acc;
		vec_word_t    r;
		acc = '0;
		if (sew != SEW64) begin
			w    = 8 << int'(sew);
			n    = 64 / w;
			a_s  = (op == OP_MULH) || (op == OP_MULHSU);
			b_s  = (op == OP_MULH);
			mask = (128'd1 << w) - 128'd1;
			for (int i = 0; i < n; i++) begin
				ea = ({64'd0, a.words} >> (i * w)) & mask;
				eb = ({64'd0, b.words} >> (i * w)) & mask;
				if (a_s && ea[w-1])
					ea = ea | ~mask;
				if (b_s && eb[w-1])
					eb = eb | ~mask;
				prod = ea * eb;
				elem = (op == OP_MUL) ? (prod & mask) : ((prod >> w) & mask);
				acc  = acc | (elem[63:0] << (i * w));
			end
		end
		r.words[0] = acc[31:0];
		r.words[1] = acc[63:32];
		return r;
	endfunction

	function automatic vec_word_t extreme(input logic [2:0] sel);
		logic [31:0] w;
		vec_word_t   v;
		case (sel)
			3'd0:    w = 32'h0000_0000;
			3'd1:    w = 32'hffff_ffff;
			3'd2:    w = 32'h8080_8080;
			3'd3:    w = 32'h7f7f_7f7f;
			3'd4:    w = 32'h8000_8000;
			3'd5:    w = 32'h7fff_7fff;
			3'd6:    w = 32'h8000_0000;
			default: w = 32'h7fff_ffff;
		endcase
		v.words[0] = w;
		v.words[1] = w;
		return v;
	endfunction

	// top bit of every element set at all widths
	function automatic vec_word_t set_top_bits(input vec_word_t v);
		vec_word_t r;
		r = v;
		r.words[0] = r.words[0] | 32'h8080_8080;
		r.words[1] = r.words[1] | 32'h8080_8080;
		return r;
	endfunction

	task automatic check_vec(input string name, input vec_word_t got, input vec_word_t exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name,
				got.words, exp.words);
			errors++;
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
		input logic [ADDR_W-1:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic check_valid(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic make_request(input int test_id, input int idx, output vec_word_t a,
		output vec_word_t b, output sew_t sew, output mul_op_t op);
		logic [31:0] r;
		r          = $random(seed);
		a.words[0] = $random(seed);
		a.words[1] = $random(seed);
		b.words[0] = $random(seed);
		b.words[1] = $random(seed);
		sew        = sew_t'(2'(idx % 3));
		case (test_id)
			2: begin
				op = OP_MUL;
				if (r[1:0] == 2'd0) begin
					a = extreme(r[4:2]);
					b = extreme(r[7:5]);
				end
			end
			3: begin
				op = r[8] ? OP_MULH : OP_MULHU;
				a  = set_top_bits(a);
				b  = set_top_bits(b);
			end
			4: begin
				op = OP_MULHSU;
				a  = set_top_bits(a);
				b  = set_top_bits(b);
			end
			default: begin
				sew = sew_t'(r[10:9]);
				op  = mul_op_t'(r[12:11]);
				if (r[13])
					a = extreme(r[16:14]);
			end
		endcase
	endtask

	task automatic check_idle(input int slots);
		int start_errors;
		start_errors = errors;
		for (int s = 0; s < slots; s++) begin
			@(negedge clk);
			check_valid("out_valid", out_valid, 1'b0);
			check_addr("out_addr", out_addr, '0);
		end
		$display("test 1 idle after reset: %0d errors", errors - start_errors);
	endtask

	task automatic run_test(input int test_id, input string label, input int slots);
		int                start_errors;
		int                start_requests;
		int                idx;
		int                drain;
		vec_word_t         a;
		vec_word_t         b;
		sew_t              sew;
		mul_op_t           op;
		logic [ADDR_W-1:0] addr;
		start_errors   = errors;
		start_requests = requests;
		idx            = 0;
		for (int s = 0; s < slots; s++) begin
			@(posedge clk);
			if ({$random(seed)} % 10 < 7) begin
				make_request(test_id, idx, a, b, sew, op);
				addr = $random(seed);
				in_valid <= 1'b1;
				in_vec0  <= a;
				in_vec1  <= b;
				in_sew   <= sew;
				in_op    <= op;
				in_addr  <= addr;
				exp_vec_q.push_back(model_mul(a, b, sew, op));
				exp_addr_q.push_back(addr);
				requests++;
				idx++;
			end else begin
				in_valid <= 1'b0;
			end
		end
		@(posedge clk);
		in_valid <= 1'b0;
		// the last response is due within the fixed latency
		drain = 0;
		while (exp_vec_q.size() != 0 && drain < LATENCY + 2) begin
			@(negedge clk);
			drain++;
		end
		$display("test %0d %s: %0d requests, %0d errors", test_id, label,
			requests - start_requests, errors - start_errors);
	endtask

	// outputs settle after the rising edge, so compare on the falling one
	always @(negedge clk) begin
		if (!rst && out_valid) begin
			if (exp_vec_q.size() == 0) begin
				$display("error at %0t: response arrived with no request pending", $time);
				errors++;
			end else begin
				check_vec("out_vec", out_vec, exp_vec_q.pop_front());
				check_addr("out_addr", out_addr, exp_addr_q.pop_front());
				responses++;
			end
		end
	end

	initial begin : watchdog
		while (cycle_count < CYCLE_LIMIT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		rst      = 1'b1;
		in_valid = 1'b0;
		in_vec0  = '0;
		in_vec1  = '0;
		in_sew   = SEW8;
		in_op    = OP_MUL;
		in_addr  = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst <= 1'b0;

		check_idle(SLOTS_IDLE);
		run_test(2, "low product", SLOTS_DIR);
		run_test(3, "high signed and unsigned", SLOTS_DIR);
		run_test(4, "high signed by unsigned", SLOTS_DIR);
		run_test(5, "mixed stream", SLOTS_MIX);

		if (exp_vec_q.size() != 0) begin
			$display("error: %0d requests still pending at the end", exp_vec_q.size());
			errors++;
		end
		if (i_dut.i_asserts.fail_count != 0) begin
			$display("error: %0d assertion failures in the DUT",
				i_dut.i_asserts.fail_count);
			errors += i_dut.i_asserts.fail_count;
		end
		$display("summary: %0d tests, %0d requests, %0d responses, %0d errors",
			NUM_TESTS, requests, responses, errors);
		if (errors == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
vmul_pkg.sv
vmul_lane.sv
vmul_decode.sv
vmul_execute.sv
vmul_result.sv
vmul_top.sv
vmul_asserts.sv
tb_vmul.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_vmul
FILELIST  ?= list.f

SOURCES := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard *.svh)
BIN     := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf obj_dir
